// ==== source/pr_accel_consts.svh ====
/*
  sizes and widths of the delta-PageRank block
*/
`ifndef PR_ACCEL_CONSTS_SVH
`define PR_ACCEL_CONSTS_SVH

// graph size
`define PR_MAX_VERTICES    16
`define PR_VID_WIDTH       4
`define PR_COUNT_WIDTH     5

// memory port
`define PR_ADDR_WIDTH      16
`define PR_DATA_WIDTH      32
`define PR_OFFSET_WIDTH    16

// edge reads in flight
`define PR_MAX_OUTSTANDING 4

`endif

// ==== source/pr_accel_pkg.sv ====
/*
  run phase enum, memory request types, vertex id and offset types
*/
`include "pr_accel_consts.svh"

package pr_accel_pkg;

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_LOAD,
    PH_RUN,
    PH_WRITE,
    PH_DONE
  } phase_e;

  typedef enum logic {
    MEM_READ,
    MEM_WRITE
  } mem_op_e;

  typedef logic [`PR_VID_WIDTH-1:0]    vid_t;
  typedef logic [`PR_OFFSET_WIDTH-1:0] offset_t;

  typedef struct packed {
    mem_op_e                   op;
    logic [`PR_ADDR_WIDTH-1:0] addr;
    logic [`PR_DATA_WIDTH-1:0] data;
  } mem_req_t;

  // one edge hit on a destination vertex
  typedef struct packed {
    vid_t dst;
  } vtx_update_t;

endpackage

// ==== source/run_control.sv ====
/*
  run_control: start edge detect, phase sequencing,
  idle/done/ready flags and the run-phase cycle counter
*/
`timescale 1ns/10ps

module run_control (
  input  logic                 ap_clk,
  input  logic                 areset,
  input  logic                 ap_start,
  input  logic                 load_done,
  input  logic                 walk_done,
  input  logic                 write_done,
  output pr_accel_pkg::phase_e phase,
  output logic [31:0]          run_cycles,
  output logic                 ap_idle,
  output logic                 ap_done,
  output logic                 ap_ready
);

  logic start_q;
  logic start_pulse;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      start_q <= 1'b0;
    end else begin
      start_q <= ap_start;
    end
  end

  assign start_pulse = ap_start & ~start_q;

  ////////////////////////////////////////////////////////////
  // phase sequencing
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      phase <= pr_accel_pkg::PH_IDLE;
    end else begin
      case (phase)
        pr_accel_pkg::PH_IDLE:  if (start_pulse) phase <= pr_accel_pkg::PH_LOAD;
        pr_accel_pkg::PH_LOAD:  if (load_done) phase <= pr_accel_pkg::PH_RUN;
        pr_accel_pkg::PH_RUN:   if (walk_done) phase <= pr_accel_pkg::PH_WRITE;
        pr_accel_pkg::PH_WRITE: if (write_done) phase <= pr_accel_pkg::PH_DONE;
        default:                phase <= pr_accel_pkg::PH_IDLE;
      endcase
    end
  end

  // cycles spent walking edges
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      run_cycles <= '0;
    end else if (phase == pr_accel_pkg::PH_IDLE && start_pulse) begin
      run_cycles <= '0;
    end else if (phase == pr_accel_pkg::PH_RUN) begin
      run_cycles <= run_cycles + 32'd1;
    end
  end

  // done lasts the single PH_DONE cycle
  assign ap_idle  = (phase == pr_accel_pkg::PH_IDLE);
  assign ap_done  = (phase == pr_accel_pkg::PH_DONE);
  assign ap_ready = ap_done;

endmodule

// ==== source/offset_table.sv ====
/*
  offset_table: loads vertex edge offsets, serves offset pairs
*/
`timescale 1ns/10ps
`include "pr_accel_consts.svh"

module offset_table (
  input  logic                          ap_clk,
  input  logic                          areset,
  input  pr_accel_pkg::phase_e          phase,
  input  logic [`PR_COUNT_WIDTH-1:0]    num_vertices,
  input  logic [`PR_ADDR_WIDTH-1:0]     offset_base,
  output pr_accel_pkg::mem_req_t        mem_req,
  output logic                          mem_req_valid,
  input  logic                          mem_req_ready,
  input  logic [`PR_DATA_WIDTH-1:0]     mem_rsp_data,
  input  logic                          mem_rsp_valid,
  output logic                          load_done,
  input  pr_accel_pkg::vid_t            rd_vid,
  output pr_accel_pkg::offset_t         loffset,
  output pr_accel_pkg::offset_t         roffset
);

  logic [`PR_COUNT_WIDTH-1:0] req_idx;
  logic [`PR_COUNT_WIDTH-1:0] rsp_idx;
  logic                       wait_rsp;
  logic                       in_load;
  logic [`PR_VID_WIDTH:0]     nxt_vid;
  pr_accel_pkg::offset_t      offs [0:`PR_MAX_VERTICES];

  assign in_load = (phase == pr_accel_pkg::PH_LOAD);

  // one word in flight, N+1 words in all
  assign mem_req_valid = in_load && !wait_rsp && (req_idx <= num_vertices);
  assign load_done     = in_load && (rsp_idx > num_vertices);

  always_comb begin
    mem_req.op   = pr_accel_pkg::MEM_READ;
    mem_req.addr = offset_base + {{(`PR_ADDR_WIDTH-`PR_COUNT_WIDTH){1'b0}}, req_idx};
    mem_req.data = '0;
  end

  always_ff @(posedge ap_clk) begin
    if (areset || !in_load) begin
      req_idx  <= '0;
      rsp_idx  <= '0;
      wait_rsp <= 1'b0;
    end else begin
      if (mem_req_valid && mem_req_ready) begin
        req_idx  <= req_idx + 1'b1;
        wait_rsp <= 1'b1;
      end
      if (wait_rsp && mem_rsp_valid) begin
        rsp_idx  <= rsp_idx + 1'b1;
        wait_rsp <= 1'b0;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (in_load && wait_rsp && mem_rsp_valid) begin
      offs[rsp_idx] <= mem_rsp_data[`PR_OFFSET_WIDTH-1:0];
    end
  end

  assign nxt_vid = {1'b0, rd_vid} + 1'b1;
  assign loffset = offs[rd_vid];
  assign roffset = offs[nxt_vid];

endmodule

// ==== source/edge_walker.sv ====
/*
  edge_walker: steps through the vertices, issues edge reads
  with a bounded count in flight, turns responses into updates
*/
`timescale 1ns/10ps
`include "pr_accel_consts.svh"

module edge_walker (
  input  logic                          ap_clk,
  input  logic                          areset,
  input  pr_accel_pkg::phase_e          phase,
  input  logic [`PR_COUNT_WIDTH-1:0]    num_vertices,
  input  logic [`PR_ADDR_WIDTH-1:0]     edge_base,
  output pr_accel_pkg::vid_t            rd_vid,
  input  pr_accel_pkg::offset_t         loffset,
  input  pr_accel_pkg::offset_t         roffset,
  output pr_accel_pkg::mem_req_t        mem_req,
  output logic                          mem_req_valid,
  input  logic                          mem_req_ready,
  input  logic [`PR_DATA_WIDTH-1:0]     mem_rsp_data,
  input  logic                          mem_rsp_valid,
  output pr_accel_pkg::vtx_update_t     update,
  output logic                          update_valid,
  output logic                          walk_done
);

  localparam int OUT_W = $clog2(`PR_MAX_OUTSTANDING + 1);

  logic [`PR_COUNT_WIDTH-1:0] cur_vid;
  pr_accel_pkg::offset_t      edge_ptr;
  logic [OUT_W-1:0]           outstanding;
  logic                       in_run;
  logic                       vid_live;
  logic                       has_edge;
  logic                       issue;
  logic                       retire;

  assign in_run   = (phase == pr_accel_pkg::PH_RUN);
  assign vid_live = (cur_vid < num_vertices);
  assign has_edge = (edge_ptr < roffset);
  assign rd_vid   = cur_vid[`PR_VID_WIDTH-1:0];

  ////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////
  assign mem_req_valid = in_run && vid_live && has_edge &&
                         (outstanding < OUT_W'(`PR_MAX_OUTSTANDING));
  assign issue  = mem_req_valid && mem_req_ready;
  assign retire = in_run && mem_rsp_valid;

  always_comb begin
    mem_req.op   = pr_accel_pkg::MEM_READ;
    mem_req.addr = edge_base + edge_ptr;
    mem_req.data = '0;
  end

  always_ff @(posedge ap_clk) begin
    if (areset || !in_run) begin
      cur_vid     <= '0;
      outstanding <= '0;
    end else begin
      // vertex exhausted or empty, move on
      if (vid_live && !has_edge) begin
        cur_vid <= cur_vid + 1'b1;
      end
      case ({issue, retire})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  // offsets are contiguous, so the pointer just keeps running
  always_ff @(posedge ap_clk) begin
    if (!in_run) begin
      edge_ptr <= loffset;
    end else if (issue) begin
      edge_ptr <= edge_ptr + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // response side
  ////////////////////////////////////////////////////////////
  assign update.dst   = mem_rsp_data[`PR_VID_WIDTH-1:0];
  assign update_valid = retire;

  assign walk_done = in_run && !vid_live && (outstanding == '0);

endmodule

// ==== source/vertex_accum.sv ====
/*
  vertex_accum: vertex values and increases, contribution add,
  active bitmap
*/
`timescale 1ns/10ps
`include "pr_accel_consts.svh"

module vertex_accum (
  input  logic                           ap_clk,
  input  logic                           areset,
  input  pr_accel_pkg::phase_e           phase,
  input  logic [31:0]                    added_const,
  input  logic [31:0]                    one_over_n,
  input  logic [31:0]                    delta2_value,
  input  pr_accel_pkg::vtx_update_t      update,
  input  logic                           update_valid,
  input  pr_accel_pkg::vid_t             rd_vid,
  output logic [`PR_DATA_WIDTH-1:0]      value,
  output logic [`PR_MAX_VERTICES-1:0]    active_bitmap
);

  logic [63:0]                 product;
  logic [31:0]                 contrib;
  pr_accel_pkg::vtx_update_t   upd_q;
  logic                        upd_valid_q;
  logic [`PR_DATA_WIDTH-1:0]   value_mem [0:`PR_MAX_VERTICES-1];
  logic [31:0]                 incr_mem  [0:`PR_MAX_VERTICES-1];

  // fixed-point scale, keep the high word
  assign product = 64'(added_const) * 64'(one_over_n);
  assign contrib = product[63:32];

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      upd_valid_q <= 1'b0;
    end else begin
      upd_valid_q <= update_valid && (phase == pr_accel_pkg::PH_RUN);
    end
  end

  always_ff @(posedge ap_clk) begin
    upd_q <= update;
  end

  always_ff @(posedge ap_clk) begin
    if (phase == pr_accel_pkg::PH_LOAD) begin
      for (int i = 0; i < `PR_MAX_VERTICES; i++) begin
        value_mem[i] <= added_const;
        incr_mem[i]  <= '0;
      end
    end else if (upd_valid_q) begin
      value_mem[upd_q.dst] <= value_mem[upd_q.dst] + contrib;
      incr_mem[upd_q.dst]  <= incr_mem[upd_q.dst] + contrib;
    end
  end

  always_comb begin
    for (int d = 0; d < `PR_MAX_VERTICES; d++) begin
      active_bitmap[d] = (incr_mem[d] > delta2_value);
    end
  end

  assign value = value_mem[rd_vid];

endmodule

// ==== source/result_writer.sv ====
/*
  result_writer: vertex values, bitmap word and cycle count
  written back in address order
*/
`timescale 1ns/10ps
`include "pr_accel_consts.svh"

module result_writer (
  input  logic                          ap_clk,
  input  logic                          areset,
  input  pr_accel_pkg::phase_e          phase,
  input  logic [`PR_COUNT_WIDTH-1:0]    num_vertices,
  input  logic [`PR_ADDR_WIDTH-1:0]     result_base,
  output pr_accel_pkg::vid_t            rd_vid,
  input  logic [`PR_DATA_WIDTH-1:0]     value,
  input  logic [`PR_MAX_VERTICES-1:0]   active_bitmap,
  input  logic [31:0]                   run_cycles,
  output pr_accel_pkg::mem_req_t        mem_req,
  output logic                          mem_req_valid,
  input  logic                          mem_req_ready,
  output logic                          write_done
);

  logic [`PR_COUNT_WIDTH:0] idx;
  logic [`PR_COUNT_WIDTH:0] n_ext;
  logic [`PR_COUNT_WIDTH:0] last_idx;
  logic                     in_write;
  logic                     fire;

  assign in_write = (phase == pr_accel_pkg::PH_WRITE);
  assign n_ext    = {1'b0, num_vertices};
  assign last_idx = n_ext + 1'b1;

  assign rd_vid        = idx[`PR_VID_WIDTH-1:0];
  assign mem_req_valid = in_write && (idx <= last_idx);
  assign fire          = mem_req_valid && mem_req_ready;
  assign write_done    = fire && (idx == last_idx);

  always_comb begin
    mem_req.op   = pr_accel_pkg::MEM_WRITE;
    mem_req.addr = result_base + {{(`PR_ADDR_WIDTH-`PR_COUNT_WIDTH-1){1'b0}}, idx};
    if (idx < n_ext) begin
      mem_req.data = value;
    end else if (idx == n_ext) begin
      mem_req.data = {{(`PR_DATA_WIDTH-`PR_MAX_VERTICES){1'b0}}, active_bitmap};
    end else begin
      mem_req.data = run_cycles;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset || !in_write) begin
      idx <= '0;
    end else if (fire) begin
      idx <= idx + 1'b1;
    end
  end

endmodule

// ==== source/pr_accel_top.sv ====
/*
  pr_accel_top: block instances and phase-selected memory port
*/
`timescale 1ns/10ps
`include "pr_accel_consts.svh"

module pr_accel_top (
  input  logic                          ap_clk,
  input  logic                          areset,
  input  logic                          ap_start,
  output logic                          ap_idle,
  output logic                          ap_done,
  output logic                          ap_ready,
  input  logic [`PR_COUNT_WIDTH-1:0]    num_vertices,
  input  logic [`PR_ADDR_WIDTH-1:0]     offset_base,
  input  logic [`PR_ADDR_WIDTH-1:0]     edge_base,
  input  logic [`PR_ADDR_WIDTH-1:0]     result_base,
  input  logic [31:0]                   added_const,
  input  logic [31:0]                   one_over_n,
  input  logic [31:0]                   delta2_value,
  output pr_accel_pkg::mem_req_t        mem_req,
  output logic                          mem_req_valid,
  input  logic                          mem_req_ready,
  input  logic [`PR_DATA_WIDTH-1:0]     mem_rsp_data,
  input  logic                          mem_rsp_valid
);

  pr_accel_pkg::phase_e        phase;
  logic [31:0]                 run_cycles;
  logic                        load_done;
  logic                        walk_done;
  logic                        write_done;

  pr_accel_pkg::mem_req_t      ot_req;
  pr_accel_pkg::mem_req_t      ew_req;
  pr_accel_pkg::mem_req_t      rw_req;
  logic                        ot_valid;
  logic                        ew_valid;
  logic                        rw_valid;
  logic                        ot_sel;
  logic                        ew_sel;
  logic                        rw_sel;

  pr_accel_pkg::vid_t          ew_vid;
  pr_accel_pkg::vid_t          rw_vid;
  pr_accel_pkg::vid_t          acc_vid;
  pr_accel_pkg::offset_t       loffset;
  pr_accel_pkg::offset_t       roffset;
  pr_accel_pkg::vtx_update_t   update;
  logic                        update_valid;
  logic [`PR_DATA_WIDTH-1:0]   value;
  logic [`PR_MAX_VERTICES-1:0] active_bitmap;

  ////////////////////////////////////////////////////////////
  // memory port owner by phase
  ////////////////////////////////////////////////////////////
  assign ot_sel  = (phase == pr_accel_pkg::PH_LOAD);
  assign ew_sel  = (phase == pr_accel_pkg::PH_RUN);
  assign rw_sel  = (phase == pr_accel_pkg::PH_WRITE);
  assign acc_vid = rw_sel ? rw_vid : ew_vid;

  always_comb begin
    case (phase)
      pr_accel_pkg::PH_LOAD: begin
        mem_req       = ot_req;
        mem_req_valid = ot_valid;
      end
      pr_accel_pkg::PH_RUN: begin
        mem_req       = ew_req;
        mem_req_valid = ew_valid;
      end
      pr_accel_pkg::PH_WRITE: begin
        mem_req       = rw_req;
        mem_req_valid = rw_valid;
      end
      default: begin
        mem_req       = '0;
        mem_req_valid = 1'b0;
      end
    endcase
  end

  run_control run_control_i (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .ap_start     (ap_start),
    .load_done    (load_done),
    .walk_done    (walk_done),
    .write_done   (write_done),
    .phase        (phase),
    .run_cycles   (run_cycles),
    .ap_idle      (ap_idle),
    .ap_done      (ap_done),
    .ap_ready     (ap_ready)
  );

  offset_table offset_table_i (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .phase         (phase),
    .num_vertices  (num_vertices),
    .offset_base   (offset_base),
    .mem_req       (ot_req),
    .mem_req_valid (ot_valid),
    .mem_req_ready (mem_req_ready & ot_sel),
    .mem_rsp_data  (mem_rsp_data),
    .mem_rsp_valid (mem_rsp_valid & ot_sel),
    .load_done     (load_done),
    .rd_vid        (ew_vid),
    .loffset       (loffset),
    .roffset       (roffset)
  );

  edge_walker edge_walker_i (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .phase         (phase),
    .num_vertices  (num_vertices),
    .edge_base     (edge_base),
    .rd_vid        (ew_vid),
    .loffset       (loffset),
    .roffset       (roffset),
    .mem_req       (ew_req),
    .mem_req_valid (ew_valid),
    .mem_req_ready (mem_req_ready & ew_sel),
    .mem_rsp_data  (mem_rsp_data),
    .mem_rsp_valid (mem_rsp_valid & ew_sel),
    .update        (update),
    .update_valid  (update_valid),
    .walk_done     (walk_done)
  );

  vertex_accum vertex_accum_i (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .phase         (phase),
    .added_const   (added_const),
    .one_over_n    (one_over_n),
    .delta2_value  (delta2_value),
    .update        (update),
    .update_valid  (update_valid),
    .rd_vid        (acc_vid),
    .value         (value),
    .active_bitmap (active_bitmap)
  );

  result_writer result_writer_i (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .phase         (phase),
    .num_vertices  (num_vertices),
    .result_base   (result_base),
    .rd_vid        (rw_vid),
    .value         (value),
    .active_bitmap (active_bitmap),
    .run_cycles    (run_cycles),
    .mem_req       (rw_req),
    .mem_req_valid (rw_valid),
    .mem_req_ready (mem_req_ready & rw_sel),
    .write_done    (write_done)
  );

endmodule

// ==== dv/tb_clock.sv ====
/*
  testbench clock (100 ns period) and 10-cycle reset
*/
`timescale 1ns/10ps

module tb_clock (
  output logic ap_clk,
  output logic areset
);

  initial begin
    ap_clk = 1'b0;
    forever #50 ap_clk = ~ap_clk;
  end

  initial begin
    areset = 1'b1;
    repeat (10) @(posedge ap_clk);
    areset <= 1'b0;
  end

endmodule

// ==== dv/pr_accel_tb.sv ====
/*
  testbench for pr_accel_top: memory model, random graphs,
  reference model, assertion checks and reporting
*/
`timescale 1ns/10ps
`include "pr_accel_consts.svh"

module pr_accel_tb;

  localparam int MAX_E = 40;

  logic                       ap_clk;
  logic                       areset;
  logic                       ap_start;
  logic                       ap_idle;
  logic                       ap_done;
  logic                       ap_ready;
  logic [`PR_COUNT_WIDTH-1:0] num_vertices;
  logic [`PR_ADDR_WIDTH-1:0]  offset_base;
  logic [`PR_ADDR_WIDTH-1:0]  edge_base;
  logic [`PR_ADDR_WIDTH-1:0]  result_base;
  logic [31:0]                added_const;
  logic [31:0]                one_over_n;
  logic [31:0]                delta2_value;
  pr_accel_pkg::mem_req_t     mem_req;
  logic                       mem_req_valid;
  logic                       mem_req_ready = 1'b0;
  logic [`PR_DATA_WIDTH-1:0]  mem_rsp_data = '0;
  logic                       mem_rsp_valid = 1'b0;

  // memory, graphs and run configuration
  logic [31:0] mem [0:65535];
  int          n_vert [2];
  int          n_edge [2];
  int          offs_ref [2][`PR_MAX_VERTICES+1];
  logic [31:0] edge_word [2][MAX_E];
  int          indeg [2][`PR_MAX_VERTICES];
  logic [15:0] ob_cfg [2];
  logic [15:0] eb_cfg [2];
  logic [15:0] rb_cfg;
  logic [31:0] ac_cfg [2];
  logic [31:0] on_cfg [2];
  logic [31:0] d2_cfg [2];

  integer      seed = 32'h256e575f;
  int          fail_cnt [1:6];
  int          cur_run = 0;
  int          write_idx = 0;
  int          cyc = 0;
  int          limit = 32'h7fffffff;
  int          now = 0;
  logic [31:0] rsp_data_q [$];
  int          rsp_due_q [$];

  // protocol monitor state
  logic                   pend_q = 1'b0;
  logic                   done_q = 1'b0;
  logic                   start_q = 1'b0;
  logic                   busy = 1'b0;
  pr_accel_pkg::mem_req_t req_q;

  tb_clock clock_i (
    .ap_clk (ap_clk),
    .areset (areset)
  );

  pr_accel_top dut_i (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .ap_start      (ap_start),
    .ap_idle       (ap_idle),
    .ap_done       (ap_done),
    .ap_ready      (ap_ready),
    .num_vertices  (num_vertices),
    .offset_base   (offset_base),
    .edge_base     (edge_base),
    .result_base   (result_base),
    .added_const   (added_const),
    .one_over_n    (one_over_n),
    .delta2_value  (delta2_value),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_data  (mem_rsp_data),
    .mem_rsp_valid (mem_rsp_valid)
  );

  ////////////////////////////////////////////////////////////
  // checks and reporting
  ////////////////////////////////////////////////////////////
  task automatic check_value(input int test, input string name,
                             input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      fail_cnt[test]++;
      $display("[FAIL] test %0d %s: got 0x%0h expected 0x%0h", test, name, got, exp);
    end
  endtask

  task automatic check_cond(input int test, input bit cond, input string msg);
    assert (cond) else begin
      fail_cnt[test]++;
      $display("test %0d error: %s", test, msg);
    end
  endtask

  task automatic report_test(input int test, input string name);
    if (fail_cnt[test] == 0) begin
      $display("test %0d %s: ok", test, name);
    end else begin
      $display("test %0d %s: %0d errors", test, name, fail_cnt[test]);
    end
  endtask

  function automatic bit read_in_range(input logic [15:0] addr);
    int ob_off;
    int eb_off;
    ob_off = int'(addr) - int'(ob_cfg[cur_run]);
    eb_off = int'(addr) - int'(eb_cfg[cur_run]);
    return (ob_off >= 0 && ob_off <= n_vert[cur_run]) ||
           (eb_off >= 0 && eb_off < n_edge[cur_run]);
  endfunction

  ////////////////////////////////////////////////////////////
  // graph generation and one run
  ////////////////////////////////////////////////////////////
  task automatic generate_graph(input int r, input int n, input int e);
    int          outdeg [`PR_MAX_VERTICES];
    int          src;
    int          dst;
    logic [31:0] rnd;
    n_vert[r] = n;
    n_edge[r] = e;
    for (int v = 0; v < `PR_MAX_VERTICES; v++) begin
      outdeg[v]   = 0;
      indeg[r][v] = 0;
    end
    for (int k = 0; k < e; k++) begin
      src = $unsigned($random(seed)) % n;
      outdeg[src]++;
    end
    // edges of a vertex sit together, in vertex order
    offs_ref[r][0] = 0;
    for (int v = 0; v < `PR_MAX_VERTICES; v++) begin
      offs_ref[r][v+1] = offs_ref[r][v] + outdeg[v];
    end
    for (int k = 0; k < e; k++) begin
      dst = $unsigned($random(seed)) % n;
      rnd = $random(seed);
      edge_word[r][k] = {rnd[31:4], 4'(dst)};
      indeg[r][dst]++;
    end
  endtask

  task automatic run_graph(input int r);
    int          n;
    logic [63:0] prod;
    logic [31:0] c;
    logic [31:0] exp_val;
    logic [15:0] exp_map;
    logic [63:0] incr;
    n = n_vert[r];
    for (int v = 0; v <= n; v++) begin
      mem[16'(ob_cfg[r] + v)] = {16'(v) ^ 16'hc3c3, 16'(offs_ref[r][v])};
    end
    for (int k = 0; k < n_edge[r]; k++) begin
      mem[16'(eb_cfg[r] + k)] = edge_word[r][k];
    end
    cur_run   = r;
    write_idx = 0;
    @(posedge ap_clk);
    num_vertices <= 5'(n);
    offset_base  <= ob_cfg[r];
    edge_base    <= eb_cfg[r];
    result_base  <= rb_cfg;
    added_const  <= ac_cfg[r];
    one_over_n   <= on_cfg[r];
    delta2_value <= d2_cfg[r];
    ap_start     <= 1'b1;
    @(posedge ap_clk);
    ap_start <= 1'b0;
    while (!ap_done) @(posedge ap_clk);
    @(posedge ap_clk);

    // reference model
    prod    = 64'(ac_cfg[r]) * 64'(on_cfg[r]);
    c       = prod[63:32];
    exp_map = '0;
    for (int d = 0; d < n; d++) begin
      exp_val    = ac_cfg[r] + 32'(indeg[r][d]) * c;
      incr       = 64'(indeg[r][d]) * 64'(c);
      exp_map[d] = (incr > 64'(d2_cfg[r]));
      check_value((r == 0) ? 2 : 6, $sformatf("value[%0d]", d),
                  mem[16'(rb_cfg + d)], exp_val);
    end
    check_value(3, "bitmap", mem[16'(rb_cfg + n)], {16'h0000, exp_map});
    check_cond(4, mem[16'(rb_cfg + n + 1)] >= 32'(n_edge[r]),
               "cycle count word is below the edge count");
    check_cond(4, write_idx == n + 2, "wrong number of result writes");
  endtask

  ////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////
  always @(posedge ap_clk) begin : mem_model
    mem_req_ready <= (($random(seed) & 3) != 0);
    mem_rsp_valid <= 1'b0;
    if (!areset && mem_req_valid && mem_req_ready) begin
      if (mem_req.op == pr_accel_pkg::MEM_READ) begin
        check_cond(4, read_in_range(mem_req.addr),
                   $sformatf("read at 0x%04h is outside the offset and edge areas",
                             mem_req.addr));
        rsp_data_q.push_back(mem[mem_req.addr]);
        rsp_due_q.push_back(now + ($random(seed) & 3));
      end else begin
        check_value(4, "mem_req.addr", mem_req.addr, 16'(rb_cfg + write_idx));
        mem[mem_req.addr] = mem_req.data;
        write_idx++;
      end
    end
    // in order, one response per cycle
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= now) begin
      mem_rsp_valid <= 1'b1;
      mem_rsp_data  <= rsp_data_q.pop_front();
      void'(rsp_due_q.pop_front());
    end
    now++;
  end

  // handshake stability and done/idle protocol
  always @(posedge ap_clk) begin
    if (!areset) begin
      if (pend_q) begin
        check_cond(5, mem_req_valid, "mem_req_valid dropped while mem_req_ready was low");
        check_value(5, "mem_req", mem_req, req_q);
      end
      check_value(5, "ap_ready", ap_ready, ap_done);
      if (done_q) begin
        check_cond(5, !ap_done, "ap_done stayed high for more than one cycle");
      end
      if (busy) begin
        check_cond(5, !ap_idle, "ap_idle went high before ap_done");
      end
      if (ap_done) begin
        busy = 1'b0;
      end else if (ap_start && !start_q && ap_idle) begin
        busy = 1'b1;
      end
      pend_q  = mem_req_valid && !mem_req_ready;
      req_q   = mem_req;
      done_q  = ap_done;
      start_q = ap_start;
    end
  end

  always @(posedge ap_clk) begin
    cyc++;
    if (cyc >= limit) begin
      $display("timeout: the runs did not finish within %0d cycles", limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////
  initial begin : stimulus
    int          n2;
    int          e2;
    int          total_req;
    int          failed_tests;
    int          failed_checks;
    logic [63:0] prod;
    ap_start     <= 1'b0;
    num_vertices <= '0;
    offset_base  <= '0;
    edge_base    <= '0;
    result_base  <= '0;
    added_const  <= '0;
    one_over_n   <= '0;
    delta2_value <= '0;
    for (int t = 1; t <= 6; t++) begin
      fail_cnt[t] = 0;
    end
    for (int a = 0; a < 65536; a++) begin
      mem[a] = {16'(~a), 16'(a)} ^ 32'h5a5a_0000;
    end

    ob_cfg[0] = 16'h0100;
    eb_cfg[0] = 16'h0200;
    ob_cfg[1] = 16'h0180;
    eb_cfg[1] = 16'h0300;
    rb_cfg    = 16'h0400;
    ac_cfg[0] = 32'h2666_6666;
    ac_cfg[1] = 32'h1999_9999;
    generate_graph(0, 16, 40);
    n2 = 6 + $unsigned($random(seed)) % 9;
    e2 = 20 + $unsigned($random(seed)) % 21;
    generate_graph(1, n2, e2);
    total_req = 0;
    for (int r = 0; r < 2; r++) begin
      on_cfg[r] = 32'hffff_ffff / n_vert[r];
      prod      = 64'(ac_cfg[r]) * 64'(on_cfg[r]);
      // threshold between one and three hits
      if (r == 0) begin
        d2_cfg[r] = 2 * prod[63:32] + 1;
      end else begin
        d2_cfg[r] = prod[63:32];
      end
      total_req += (n_vert[r] + 1) + n_edge[r] + (n_vert[r] + 2);
    end
    limit = total_req * 8 + 200;

    @(posedge ap_clk);
    while (areset) @(posedge ap_clk);
    repeat (4) begin
      @(posedge ap_clk);
      check_value(1, "ap_idle", ap_idle, 1'b1);
      check_value(1, "ap_done", ap_done, 1'b0);
      check_value(1, "mem_req_valid", mem_req_valid, 1'b0);
    end
    report_test(1, "reset state");

    run_graph(0);
    report_test(2, "run 1 vertex values");
    run_graph(1);
    report_test(3, "bitmap words");
    report_test(4, "address order and ranges");
    report_test(6, "run 2 vertex values");
    repeat (3) @(posedge ap_clk);
    report_test(5, "handshake and done protocol");

    failed_tests  = 0;
    failed_checks = 0;
    for (int t = 1; t <= 6; t++) begin
      failed_checks += fail_cnt[t];
      if (fail_cnt[t] != 0) begin
        failed_tests++;
      end
    end
    $display("summary: 6 tests, %0d failed, %0d failed checks", failed_tests, failed_checks);
    if (failed_checks == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+source
source/pr_accel_pkg.sv
source/run_control.sv
source/offset_table.sv
source/edge_walker.sv
source/vertex_accum.sv
source/result_writer.sv
source/pr_accel_top.sv
dv/tb_clock.sv
dv/pr_accel_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module pr_accel_tb -f files.f -o sim_pr_accel
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_pr_accel > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then
  exit 0
fi
exit 1
